/* src/st_glue_pkg.sv */
// ----------------------------------------------------------
// shared constants, widths, typedefs and bus structs
// for the ST glue block, plus the reset sequencer states
// ----------------------------------------------------------
`default_nettype none

package st_glue_pkg;

	// clocks in Hz
	localparam logic [31:0] SYSTEM_CLOCK = 32'd32084988;
	localparam logic [31:0] MFP_CLOCK    = 32'd2457600;  // 2.4576 MHz

	// reset sequencer
	localparam logic [6:0] RESET_CYCLES  = 7'd127;  // counter reload
	localparam logic [6:0] MCU_RESET_ON  = 7'd10;
	localparam logic [6:0] MCU_RESET_OFF = 7'd8;

	// GEMDOS counts years from 1980
	localparam logic [3:0] RTC_YEAR_FIX = 4'd2;

	typedef logic [6:0]  rst_cnt_t;
	typedef logic [3:0]  nibble_t;
	typedef logic [3:0]  rtc_reg_t;    // A4..A1
	typedef logic [51:0] rtc_time_t;   // wday, year, month, day, hour, min, sec

	typedef struct packed {
		rtc_reg_t reg_sel;
		nibble_t  wdata;
		logic     cs_n;
		logic     wr_n;
	} rtc_bus_t;

	typedef logic [9:0]  ym_sample_t;   // unsigned
	typedef logic [7:0]  ste_sample_t;  // unsigned
	typedef logic [14:0] audio_out_t;

	typedef struct packed {
		ste_sample_t left;
		ste_sample_t right;
	} ste_pair_t;

	typedef enum logic [1:0] {
		RS_HOLD,       // counting down, MCU reset not yet pulsed
		RS_MCU_PULSE,  // MCU reset low
		RS_RUN
	} rst_state_e;

endpackage

`default_nettype wire

/* src/reset_seq.sv */
// ----------------------------------------------------------
// reset sequencer: system reset counter, peripheral reset
// and the pulsed MCU reset
// ----------------------------------------------------------
`default_nettype none

module reset_seq (
	input  logic clk_32,
	input  logic xsint,
	input  logic ext_reset_n_i,
	input  logic cpu_reset_n_i,   // CPU RESET output
	output logic sys_reset_o,
	output logic periph_reset_o,
	output logic mcu_reset_n_o
);
	import st_glue_pkg::*;

	rst_cnt_t   rst_cnt;
	rst_state_e state;
	logic       cpu_reset_n_d;    // previous sample
	logic       cpu_reset_fall;

	assign cpu_reset_fall = cpu_reset_n_d & ~cpu_reset_n_i;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			rst_cnt        <= RESET_CYCLES;
			state          <= RS_HOLD;
			sys_reset_o    <= 1'b1;
			periph_reset_o <= 1'b1;
			mcu_reset_n_o  <= 1'b1;  // MCU stays out of reset at power-on
			cpu_reset_n_d  <= 1'b1;
		end else begin
			cpu_reset_n_d  <= cpu_reset_n_i;
			periph_reset_o <= sys_reset_o | ~cpu_reset_n_i;
			if (!ext_reset_n_i) begin
				rst_cnt     <= RESET_CYCLES;  // reload, restart sequence
				state       <= RS_HOLD;
				sys_reset_o <= 1'b1;
			end else begin
				sys_reset_o <= (rst_cnt != '0);
				if (rst_cnt != '0)
					rst_cnt <= rst_cnt - 1'b1;
				// MCU reset window inside the count-down
				case (state)
					RS_HOLD: if (rst_cnt == MCU_RESET_ON) begin
						mcu_reset_n_o <= 1'b0;
						state         <= RS_MCU_PULSE;
					end
					RS_MCU_PULSE: if (rst_cnt < MCU_RESET_OFF) begin
						mcu_reset_n_o <= 1'b1;
						state         <= RS_RUN;
					end
					default: ;  // RS_RUN waits for next reload
				endcase
			end
			// CPU RESET instruction re-pulses the MCU, held till next window
			if (cpu_reset_fall)
				mcu_reset_n_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* src/mfp_clk_gen.sv */
// ----------------------------------------------------------
// MFP clock generator, 2.4576 MHz from the system clock
// via a fractional phase accumulator
// ----------------------------------------------------------
`default_nettype none

module mfp_clk_gen (
	input  logic clk_32,
	input  logic xsint,
	output logic mfp_clk_o   // level clock, toggles every 6 or 7 cycles
);
	import st_glue_pkg::*;

	logic [31:0] phase_acc;

	// each toggle is half a period, so compare against half the clock
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			phase_acc <= '0;
			mfp_clk_o <= 1'b0;
		end else if (phase_acc < SYSTEM_CLOCK / 2) begin
			phase_acc <= phase_acc + MFP_CLOCK;
		end else begin
			// keep the remainder, no long-term drift
			phase_acc <= phase_acc - (SYSTEM_CLOCK / 2 - MFP_CLOCK);
			mfp_clk_o <= ~mfp_clk_o;
		end
	end

endmodule

`default_nettype wire

/* src/rtc_rp5c15.sv */
// ----------------------------------------------------------
// RP5C15 real-time clock registers: time readout,
// bank bit, bank-1 nibble RAM, GEMDOS year fix
// ----------------------------------------------------------
`default_nettype none

module rtc_rp5c15 (
	input  logic                  clk_32,
	input  logic                  xsint,
	input  logic                  periph_reset_i,
	input  st_glue_pkg::rtc_bus_t  bus_i,
	input  st_glue_pkg::rtc_time_t time_i,
	output st_glue_pkg::nibble_t   rdata_o     // combinational read
);
	import st_glue_pkg::*;

	nibble_t ram [16];   // bank 1 scratch RAM, entry D unused
	logic    bank;
	logic    wr_en;
	nibble_t bank0_nib;
	nibble_t year_tens;

	assign wr_en     = ~(bus_i.cs_n | bus_i.wr_n);
	assign year_tens = time_i[47:44] + RTC_YEAR_FIX;  // wraps mod 16

	// bank 0 time digits
	always_comb begin
		case (bus_i.reg_sel)
			4'h0: bank0_nib = time_i[3:0];     // sec
			4'h1: bank0_nib = time_i[7:4];
			4'h2: bank0_nib = time_i[11:8];    // min
			4'h3: bank0_nib = time_i[15:12];
			4'h4: bank0_nib = time_i[19:16];   // hour
			4'h5: bank0_nib = time_i[23:20];
			4'h6: bank0_nib = time_i[51:48];   // weekday
			4'h7: bank0_nib = time_i[27:24];   // day
			4'h8: bank0_nib = time_i[31:28];
			4'h9: bank0_nib = time_i[35:32];   // month
			4'ha: bank0_nib = time_i[39:36];
			4'hb: bank0_nib = time_i[43:40];   // year
			4'hc: bank0_nib = year_tens;
			default: bank0_nib = 4'hf;         // D..F decoded below
		endcase
	end

	// read mux, D..F visible in both banks
	always_comb begin
		case (bus_i.reg_sel)
			4'hd: rdata_o = {1'b1, 2'b00, bank};
			4'he: rdata_o = 4'h0;
			4'hf: rdata_o = 4'hc;
			default: rdata_o = bank ? ram[bus_i.reg_sel] : bank0_nib;
		endcase
		// no time from the host yet, hide the chip
		if (time_i == '0)
			rdata_o = 4'hf;
	end

	// bank select lives in register D
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint)
			bank <= 1'b0;
		else if (periph_reset_i)
			bank <= 1'b0;
		else if (wr_en && bus_i.reg_sel == 4'hd)
			bank <= bus_i.wdata[0];
	end

	// every other register writes the RAM, either bank
	always_ff @(posedge clk_32) begin
		if (wr_en && bus_i.reg_sel != 4'hd)
			ram[bus_i.reg_sel] <= bus_i.wdata;
	end

endmodule

`default_nettype wire

/* src/audio_mix.sv */
// ----------------------------------------------------------
// audio mixer: YM and STe DMA samples widened to 15 bits,
// summed and registered per channel
// ----------------------------------------------------------
`default_nettype none

module audio_mix (
	input  logic                   clk_32,
	input  logic                   xsint,
	input  st_glue_pkg::ym_sample_t ym_i,    // feeds both channels
	input  st_glue_pkg::ste_pair_t  ste_i,
	output st_glue_pkg::audio_out_t left_o,
	output st_glue_pkg::audio_out_t right_o
);
	import st_glue_pkg::*;

	// offset binary to two's complement, then scale up by
	// repeating the top bits into the low end
	function automatic audio_out_t mix(input ym_sample_t ym, input ste_sample_t ste);
		ym_sample_t  ym_s;
		ste_sample_t ste_s;
		ym_s  = {~ym[9], ym[8:0]};    // minus 0x200
		ste_s = {~ste[7], ste[6:0]};  // minus 0x80
		return {ym_s[9], ym_s, ym_s[9:6]} + {ste_s[7], ste_s, ste_s[7:2]};
	endfunction

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			left_o  <= '0;
			right_o <= '0;
		end else begin
			left_o  <= mix(ym_i, ste_i.left);
			right_o <= mix(ym_i, ste_i.right);
		end
	end

endmodule

`default_nettype wire

/* src/st_glue.sv */
// ----------------------------------------------------------
// ST glue top level: reset sequencer, MFP clock,
// RTC registers and audio mixer
// ----------------------------------------------------------
`default_nettype none

module st_glue (
	input  logic                   clk_32,
	input  logic                   xsint,           // power-on reset, low
	input  logic                   ext_reset_n_i,
	input  logic                   cpu_reset_n_i,   // CPU RESET output
	input  st_glue_pkg::rtc_bus_t   rtc_bus_i,
	input  st_glue_pkg::rtc_time_t  rtc_time_i,      // BCD time from host
	input  st_glue_pkg::ym_sample_t ym_snd_i,
	input  st_glue_pkg::ste_pair_t  ste_snd_i,
	output logic                   sys_reset_o,
	output logic                   periph_reset_o,
	output logic                   mcu_reset_n_o,
	output logic                   mfp_clk_o,
	output st_glue_pkg::nibble_t    rtc_rdata_o,
	output st_glue_pkg::audio_out_t audio_l_o,
	output st_glue_pkg::audio_out_t audio_r_o
);

	reset_seq u_reset_seq (
		.clk_32         (clk_32),
		.xsint          (xsint),
		.ext_reset_n_i  (ext_reset_n_i),
		.cpu_reset_n_i  (cpu_reset_n_i),
		.sys_reset_o    (sys_reset_o),
		.periph_reset_o (periph_reset_o),
		.mcu_reset_n_o  (mcu_reset_n_o)
	);

	// clock for the MFP timers
	mfp_clk_gen u_mfp_clk_gen (
		.clk_32    (clk_32),
		.xsint     (xsint),
		.mfp_clk_o (mfp_clk_o)
	);

	// peripheral reset clears the RTC bank bit
	rtc_rp5c15 u_rtc (
		.clk_32         (clk_32),
		.xsint          (xsint),
		.periph_reset_i (periph_reset_o),
		.bus_i          (rtc_bus_i),
		.time_i         (rtc_time_i),
		.rdata_o        (rtc_rdata_o)
	);

	audio_mix u_audio_mix (
		.clk_32  (clk_32),
		.xsint   (xsint),
		.ym_i    (ym_snd_i),
		.ste_i   (ste_snd_i),
		.left_o  (audio_l_o),
		.right_o (audio_r_o)
	);

endmodule

`default_nettype wire

/* bench/st_glue_checker.sv */
// ----------------------------------------------------------
// concurrent assertions on the reset sequence, CPU reset,
// MFP clock spacing and the audio mixing rule
// ----------------------------------------------------------
`default_nettype none

module st_glue_checker (
	input logic                    clk_32,
	input logic                    xsint,
	input logic                    ext_reset_n_i,
	input logic                    cpu_reset_n_i,
	input logic                    sys_reset_o,
	input logic                    periph_reset_o,
	input logic                    mcu_reset_n_o,
	input logic                    mfp_clk_o,
	input st_glue_pkg::ym_sample_t  ym_snd_i,
	input st_glue_pkg::ste_pair_t   ste_snd_i,
	input st_glue_pkg::audio_out_t  audio_l_o,
	input st_glue_pkg::audio_out_t  audio_r_o
);
	timeunit 1ns;
	timeprecision 100ps;
	import st_glue_pkg::*;

	int         err_cnt = 0;  // polled by the testbench
	logic [7:0] since_load;   // cycles since last reload, saturates
	logic       cpu_d;
	logic       cpu_seen;     // MCU window no longer plain after this
	logic       mfp_d;
	logic [3:0] mfp_gap;      // cycles since last toggle
	logic       mfp_armed;    // first toggle seen
	logic       mix_armed;
	audio_out_t exp_l;
	audio_out_t exp_r;

	// offset binary to signed, scaled to 15 bits with the top bits as fill
	function automatic audio_out_t mix_ref(input int ym, input int ste);
		int acc;
		acc = (ym - 512) * 16 + (((ym ^ 512) >> 6) & 15);
		acc = acc + (ste - 128) * 64 + (((ste ^ 128) >> 2) & 63);
		return audio_out_t'(acc & 32'h7fff);  // mod 2^15
	endfunction

	always_comb begin
		exp_l = mix_ref(int'(ym_snd_i), int'(ste_snd_i.left));
		exp_r = mix_ref(int'(ym_snd_i), int'(ste_snd_i.right));
	end

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			since_load <= '0;
			cpu_d      <= 1'b1;
			cpu_seen   <= 1'b0;
			mfp_d      <= 1'b0;
			mfp_gap    <= '0;
			mfp_armed  <= 1'b0;
			mix_armed  <= 1'b0;
		end else begin
			mix_armed <= 1'b1;
			cpu_d     <= cpu_reset_n_i;
			cpu_seen  <= cpu_seen | (cpu_d & ~cpu_reset_n_i);
			mfp_d     <= mfp_clk_o;
			if (!ext_reset_n_i)
				since_load <= '0;
			else if (since_load != 8'hff)
				since_load <= since_load + 8'd1;
			if (mfp_clk_o != mfp_d) begin
				mfp_gap   <= 4'd1;
				mfp_armed <= 1'b1;
			end else if (mfp_gap != 4'hf)
				mfp_gap <= mfp_gap + 4'd1;
		end
	end

	// high for 128 cycles after the last reload
	a_sys_len: assert property (@(posedge clk_32) disable iff (!xsint)
		sys_reset_o == (since_load < 8'd128))
		else begin err_cnt++; $error("sys_reset_o wrong at %0d after reload", since_load); end

	// low after cycles 118..120 of the count-down, counter at 10 down to 8
	a_mcu_win: assert property (@(posedge clk_32) disable iff (!xsint)
		!cpu_seen |-> mcu_reset_n_o == !(since_load >= 8'd118 && since_load <= 8'd120))
		else begin err_cnt++; $error("MCU reset window wrong at %0d", since_load); end

	a_mcu_cpu: assert property (@(posedge clk_32) disable iff (!xsint)
		$fell(cpu_reset_n_i) |=> !mcu_reset_n_o)
		else begin err_cnt++; $error("MCU reset not low after CPU RESET"); end

	a_periph: assert property (@(posedge clk_32) disable iff (!xsint)
		(sys_reset_o || !cpu_reset_n_i) |=> periph_reset_o)
		else begin err_cnt++; $error("peripheral reset missing"); end

	a_mfp_gap: assert property (@(posedge clk_32) disable iff (!xsint)
		(mfp_armed && mfp_clk_o != mfp_d) |-> (mfp_gap == 4'd6 || mfp_gap == 4'd7))
		else begin err_cnt++; $error("MFP toggle after %0d cycles", mfp_gap); end

	a_mix_l: assert property (@(posedge clk_32) disable iff (!xsint)
		mix_armed |-> audio_l_o == $past(exp_l))
		else begin err_cnt++; $error("left audio %h wrong", audio_l_o); end

	a_mix_r: assert property (@(posedge clk_32) disable iff (!xsint)
		mix_armed |-> audio_r_o == $past(exp_r))
		else begin err_cnt++; $error("right audio %h wrong", audio_r_o); end

endmodule

`default_nettype wire

/* bench/tb_st_glue.sv */
// ----------------------------------------------------------
// testbench for the ST glue block with clock, reset,
// stimulus, RTC readback checks, MFP toggle count and timeout
// ----------------------------------------------------------
`default_nettype none

module tb_st_glue;
	timeunit 1ns;
	timeprecision 100ps;
	import st_glue_pkg::*;

	localparam int TIMEOUT_CYCLES = 3000;  // tests need about 1400

	logic       clk_32;
	logic       xsint;
	logic       ext_reset_n;
	logic       cpu_reset_n;
	rtc_bus_t   rtc_bus;
	rtc_time_t  rtc_time;
	ym_sample_t ym_snd;
	ste_pair_t  ste_snd;
	logic       sys_reset;
	logic       periph_reset;
	logic       mcu_reset_n;
	logic       mfp_clk;
	nibble_t    rtc_rdata;
	audio_out_t audio_l;
	audio_out_t audio_r;
	nibble_t    reg_dig [13];  // time digit per bank 0 register
	int         cycles = 0;

	st_glue UUT (
		.clk_32(clk_32), .xsint(xsint),
		.ext_reset_n_i(ext_reset_n), .cpu_reset_n_i(cpu_reset_n),
		.rtc_bus_i(rtc_bus), .rtc_time_i(rtc_time),
		.ym_snd_i(ym_snd), .ste_snd_i(ste_snd),
		.sys_reset_o(sys_reset), .periph_reset_o(periph_reset),
		.mcu_reset_n_o(mcu_reset_n), .mfp_clk_o(mfp_clk),
		.rtc_rdata_o(rtc_rdata), .audio_l_o(audio_l), .audio_r_o(audio_r)
	);

	bind st_glue st_glue_checker u_chk (.*);

	initial begin
		clk_32 = 1'b0;
		forever #2 clk_32 = ~clk_32;  // 4 ns
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "run stopped");
	endtask

	always @(posedge clk_32) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES)
			abort_run("timeout: the tests did not finish within the cycle limit");
	end

	always @(negedge clk_32)
		if (UUT.u_chk.err_cnt != 0)
			abort_run("a checker assertion failed, see the error above");

	// combinational read sampled at the falling edge
	task automatic read_check(input rtc_reg_t sel, input nibble_t exp);
		@(posedge clk_32);
		rtc_bus <= '{reg_sel: sel, wdata: 4'h0, cs_n: 1'b0, wr_n: 1'b1};
		@(negedge clk_32);
		if (rtc_rdata !== exp)
			abort_run($sformatf("[FAIL] %0d ns: RTC reg %h read %h, expected %h",
				$time, sel, rtc_rdata, exp));
	endtask

	task automatic write_reg(input rtc_reg_t sel, input nibble_t data);
		@(posedge clk_32);
		rtc_bus <= '{reg_sel: sel, wdata: data, cs_n: 1'b0, wr_n: 1'b0};
		@(posedge clk_32);  // write lands here
		rtc_bus <= '{reg_sel: sel, wdata: data, cs_n: 1'b1, wr_n: 1'b1};
	endtask

	task automatic count_mfp_toggles();
		int   n;
		logic prev;
		n = 0;
		@(negedge clk_32);
		prev = mfp_clk;
		repeat (1000) begin
			@(negedge clk_32);
			if (mfp_clk != prev)
				n++;
			prev = mfp_clk;
		end
		// 1000 / 6.53 cycles per half period
		if (n < 152 || n > 154)
			abort_run($sformatf("[FAIL] %0d ns: %0d MFP toggles in 1000 cycles, expected 152..154",
				$time, n));
	endtask

	task automatic load_random_time();
		for (int r = 0; r < 13; r++)
			reg_dig[r] = nibble_t'($urandom_range(9));
		reg_dig[6] = nibble_t'($urandom_range(7, 1));  // weekday 1..7 keeps the time nonzero
		@(posedge clk_32);
		rtc_time <= {reg_dig[6], reg_dig[12], reg_dig[11], reg_dig[10], reg_dig[9],
			reg_dig[8], reg_dig[7], reg_dig[5], reg_dig[4], reg_dig[3],
			reg_dig[2], reg_dig[1], reg_dig[0]};
	endtask

	initial begin
		nibble_t ram_exp [13];
		void'($urandom(32'hb5df));
		xsint       = 1'b0;
		ext_reset_n = 1'b1;
		cpu_reset_n = 1'b1;
		rtc_bus     = '{reg_sel: 4'h0, wdata: 4'h0, cs_n: 1'b1, wr_n: 1'b1};
		rtc_time    = '0;
		ym_snd      = '0;
		ste_snd     = '0;
		repeat (3) @(posedge clk_32);
		xsint <= 1'b1;
		do @(negedge clk_32); while (sys_reset);  // power-on count-down
		@(posedge clk_32);
		ext_reset_n <= 1'b0;  // mid-run external reset
		repeat (2) @(posedge clk_32);
		ext_reset_n <= 1'b1;
		do @(negedge clk_32); while (sys_reset);
		repeat (20) begin
			@(posedge clk_32);
			ym_snd        <= ym_sample_t'($urandom);
			ste_snd.left  <= ste_sample_t'($urandom);
			ste_snd.right <= ste_sample_t'($urandom);
		end
		@(posedge clk_32);
		ym_snd  <= '0;
		ste_snd <= '0;
		repeat (4) @(posedge clk_32);
		ym_snd  <= '1;
		ste_snd <= '1;
		repeat (4) @(posedge clk_32);
		count_mfp_toggles();
		// bank 0 time readout
		load_random_time();
		for (int r = 0; r < 12; r++)
			read_check(rtc_reg_t'(r), reg_dig[r]);
		read_check(4'hc, reg_dig[12] + RTC_YEAR_FIX);  // GEMDOS year offset
		read_check(4'hd, 4'h8);
		read_check(4'he, 4'h0);
		read_check(4'hf, 4'hc);
		// bank 1 scratch RAM
		write_reg(4'hd, 4'h1);
		read_check(4'hd, 4'h9);
		for (int r = 0; r < 13; r++) begin
			ram_exp[r] = nibble_t'($urandom);
			write_reg(rtc_reg_t'(r), ram_exp[r]);
		end
		for (int r = 0; r < 13; r++)
			read_check(rtc_reg_t'(r), ram_exp[r]);
		@(posedge clk_32);
		cpu_reset_n <= 1'b0;  // CPU RESET raises the peripheral reset which drops the bank
		repeat (2) @(posedge clk_32);
		cpu_reset_n <= 1'b1;
		read_check(4'hd, 4'h8);
		// with no time loaded every register reads hex F
		@(posedge clk_32);
		rtc_time <= '0;
		for (int r = 0; r < 16; r++)
			read_check(rtc_reg_t'(r), 4'hf);
		repeat (4) @(posedge clk_32);
		@(negedge clk_32);
		if (UUT.u_chk.err_cnt != 0)
			abort_run("a checker assertion failed, see the error above");
		else begin
			$display("TB PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* compile.f */
src/st_glue_pkg.sv
src/reset_seq.sv
src/mfp_clk_gen.sv
src/rtc_rp5c15.sv
src/audio_mix.sv
src/st_glue.sv
bench/st_glue_checker.sv
bench/tb_st_glue.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the ST glue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_st_glue -f compile.f -o sim_st_glue
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

# checker errors must not stop the run before the testbench reports them
sim_out=$(./obj_dir/sim_st_glue +verilator+error+limit+100 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi
if echo "$sim_out" | grep -q "%Error"; then
	echo "errors reported during simulation"
	exit 1
fi
if echo "$sim_out" | grep -qx "TB PASSED"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
